//--- dm_top.f
src/dm_pkg.sv
src/dm_access_if.sv
src/dm_decode.sv
src/dm_execute.sv
src/dm_result.sv
src/dm_top.sv
bench/hart_model.sv
bench/dm_tb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module dm_tb -f dm_top.f -o dm_sim
./obj_dir/dm_sim > sim.log 2>&1
cat sim.log

if grep -q "Regression failed" sim.log; then
    echo "Simulation reported failure"
    exit 1
fi
echo "Simulation reported no failure"

//--- bench/dm_tb.sv
`timescale 1ns/1ps
`default_nettype none

module dm_tb import dm_pkg::*; ();

    logic      clk, dm_reset, dmi_req, dmi_write, dmi_ack;
    dmi_addr_t dmi_addr;
    dmi_data_t dmi_wdata, dmi_rdata;
    logic      halt_req, resume_req, exec, ndm_reset_out, hart_reset_out;
    dmi_data_t command, data0_out, data1_out, data0_in;
    logic      halted, done, exception, error, data0_we, stall;

    logic      rd_chk, pin_chk, no_halt_chk, d1_chk;
    logic [1:0] pin_exp;            // {ndm_reset_out, hart_reset_out}
    dmi_data_t exp_mask, exp_val, v, cmd_exp;
    int        errors = 0;

    dm_top dut (
        .clk (clk), .dm_reset (dm_reset),
        .dmi_req (dmi_req), .dmi_write (dmi_write), .dmi_addr (dmi_addr),
        .dmi_wdata (dmi_wdata), .dmi_ack (dmi_ack), .dmi_rdata (dmi_rdata),
        .halt_req (halt_req), .resume_req (resume_req), .exec (exec),
        .command (command), .data0_out (data0_out), .data1_out (data1_out),
        .halted (halted), .done (done), .exception (exception), .error (error),
        .data0_in (data0_in), .data0_we (data0_we),
        .ndm_reset_out (ndm_reset_out), .hart_reset_out (hart_reset_out)
    );

    hart_model hart (
        .clk (clk), .dm_reset (dm_reset), .halt_req (halt_req),
        .resume_req (resume_req), .exec (exec), .hart_reset (hart_reset_out),
        .stall (stall), .command (command), .data0_out (data0_out),
        .halted (halted), .done (done), .exception (exception), .error (error),
        .data0_we (data0_we), .data0_in (data0_in)
    );

    task automatic flag_error(input string msg);
        errors++;
        $display("CHECK FAILED at %0t: %s", $time, msg);
    endtask

    assert property (@(posedge clk) disable iff (dm_reset) $rose(dmi_req) |-> ##3 $rose(dmi_ack))
        else flag_error("ack did not rise 2 cycles after the edge that saw req");
    assert property (@(posedge clk) disable iff (dm_reset)
        (rd_chk && dmi_ack) |-> ((dmi_rdata & exp_mask) == exp_val))
        else flag_error($sformatf("read of 0x%02h gave 0x%08h, expected 0x%08h under 0x%08h",
                                  dmi_addr, dmi_rdata, exp_val, exp_mask));
    assert property (@(posedge clk) $fell(dm_reset) |->
        !(dmi_ack || halt_req || resume_req || exec || ndm_reset_out || hart_reset_out))
        else flag_error("outputs active right after reset");
    assert property (@(posedge clk) disable iff (dm_reset)
        pin_chk |-> ({ndm_reset_out, hart_reset_out} == pin_exp))
        else flag_error("reset outputs do not match the dmcontrol write");
    assert property (@(posedge clk) disable iff (dm_reset) no_halt_chk |-> !halt_req)
        else flag_error("halt_req raised while dmactive is 0");
    assert property (@(posedge clk) disable iff (dm_reset) resume_req |=> !resume_req)
        else flag_error("resume_req longer than one cycle");
    assert property (@(posedge clk) disable iff (dm_reset) (done || exception || error) |=> !exec)
        else flag_error("exec still high after the hart finished");
    assert property (@(posedge clk) disable iff (dm_reset) exec |-> (command == cmd_exp))
        else flag_error($sformatf("command 0x%08h, expected 0x%08h", command, cmd_exp));
    assert property (@(posedge clk) disable iff (dm_reset) d1_chk |-> (data1_out == ~v))
        else flag_error($sformatf("data1_out 0x%08h, expected 0x%08h", data1_out, ~v));

    function automatic dmi_data_t dmcontrol_bit(input int pos);
        return dmi_data_t'(1) << pos;
    endfunction

    // Called on a falling edge, returns on a falling edge with ack low
    task automatic dmi_write_reg(input dmi_addr_t addr, input dmi_data_t data);
        dmi_addr  = addr;
        dmi_wdata = data;
        dmi_write = 1'b1;
        dmi_req   = 1'b1;
        do @(negedge clk); while (!dmi_ack);
        dmi_req = 1'b0;
        do @(negedge clk); while (dmi_ack);
    endtask

    task automatic dmi_read_reg(input dmi_addr_t addr, output dmi_data_t data);
        dmi_addr  = addr;
        dmi_write = 1'b0;
        dmi_req   = 1'b1;
        do @(negedge clk); while (!dmi_ack);
        data    = dmi_rdata;
        dmi_req = 1'b0;
        do @(negedge clk); while (dmi_ack);
    endtask

    task automatic check_reg(input dmi_addr_t addr, input dmi_data_t mask, input dmi_data_t val);
        dmi_data_t d;
        exp_mask = mask;
        exp_val  = val & mask;
        rd_chk   = 1'b1;
        dmi_read_reg(addr, d);
        rd_chk   = 1'b0;
    endtask

    task automatic wait_idle();
        dmi_data_t d;
        do dmi_read_reg(addr_abstractcs, d); while (d[12]); // busy
    endtask

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Whole sequence is about 60 DMI accesses of 5 to 15 cycles each
    initial begin
        repeat (2000) @(posedge clk);
        $display("Timeout: test sequence did not finish within 2000 cycles");
        $display("Regression failed");
        $finish;
    end

    initial begin
        dm_reset    = 1'b1;
        dmi_req     = 1'b0;
        dmi_write   = 1'b0;
        dmi_addr    = '0;
        dmi_wdata   = '0;
        stall       = 1'b0;
        rd_chk      = 1'b0;
        pin_chk     = 1'b0;
        no_halt_chk = 1'b0;
        d1_chk      = 1'b0;
        pin_exp     = 2'b00;
        exp_mask    = '0;
        exp_val     = '0;
        cmd_exp     = '0;
        void'($urandom(60));
        repeat (2) @(posedge clk);
        @(negedge clk);
        dm_reset = 1'b0;

        // Inactive module ignores writes
        no_halt_chk = 1'b1;
        dmi_write_reg(addr_data0, 32'h0000_0055);
        dmi_write_reg(addr_dmcontrol, dmcontrol_bit(pos_haltreq));
        check_reg(addr_data0, '1, 32'd0);
        no_halt_chk = 1'b0;
        dmi_write_reg(addr_dmcontrol, dmcontrol_bit(pos_dmactive));
        check_reg(addr_dmcontrol, 32'h1, 32'h1);

        // Halt then resume
        dmi_write_reg(addr_dmcontrol, dmcontrol_bit(pos_haltreq) | dmcontrol_bit(pos_dmactive));
        check_reg(addr_dmstatus, 32'h0000_0300, 32'h0000_0300);
        check_reg(addr_haltsum0, '1, 32'd1);
        dmi_write_reg(addr_dmcontrol, dmcontrol_bit(pos_resumereq) | dmcontrol_bit(pos_dmactive));
        check_reg(addr_dmstatus, 32'h0003_0F00, 32'h0003_0C00);

        // Command returns data0 + 1
        v       = $urandom;
        stall   = 1'b1;
        cmd_exp = 32'h0022_1008;
        dmi_write_reg(addr_data0, v);
        dmi_write_reg(addr_command, cmd_exp);
        check_reg(addr_abstractcs, 32'h0000_1000, 32'h0000_1000);
        stall = 1'b0;
        wait_idle();
        check_reg(addr_data0, '1, v + 1);
        check_reg(addr_abstractcs, 32'h0000_0700, 32'd0);
        dmi_write_reg(addr_data1, ~v);
        d1_chk = 1'b1;
        check_reg(addr_data1, '1, ~v);
        d1_chk = 1'b0;

        // Command write while busy
        stall   = 1'b1;
        cmd_exp = 32'h0022_1008;
        dmi_write_reg(addr_command, cmd_exp);
        dmi_write_reg(addr_command, 32'h0022_1009);
        check_reg(addr_abstractcs, 32'h0000_1700, 32'h0000_1100);
        stall = 1'b0;
        wait_idle();
        dmi_write_reg(addr_abstractcs, 32'h0000_0700);
        check_reg(addr_abstractcs, 32'h0000_0700, 32'd0);

        // Exception, then a blocked command
        cmd_exp = 32'h0022_1009;
        dmi_write_reg(addr_command, cmd_exp);
        wait_idle();
        check_reg(addr_abstractcs, 32'h0000_0700, 32'h0000_0300);
        dmi_write_reg(addr_command, 32'h0022_1008);
        check_reg(addr_abstractcs, 32'h0000_1700, 32'h0000_0300);
        dmi_write_reg(addr_abstractcs, 32'h0000_0700);

        // Hart error gives cmderr 5
        cmd_exp = 32'h0022_100A;
        dmi_write_reg(addr_command, cmd_exp);
        wait_idle();
        check_reg(addr_abstractcs, 32'h0000_0700, 32'h0000_0500);
        dmi_write_reg(addr_abstractcs, 32'h0000_0700);
        check_reg(addr_abstractcs, 32'h0000_0700, 32'd0);

        // ndmreset and hartreset, havereset until acknowledged
        dmi_write_reg(addr_dmcontrol, dmcontrol_bit(pos_ndmreset) | dmcontrol_bit(pos_dmactive));
        pin_exp = 2'b11;
        pin_chk = 1'b1;
        check_reg(addr_dmstatus, 32'h000C_3000, 32'h000C_3000);
        pin_chk = 1'b0;
        dmi_write_reg(addr_dmcontrol, dmcontrol_bit(pos_dmactive));
        dmi_write_reg(addr_dmcontrol, dmcontrol_bit(pos_hartreset) | dmcontrol_bit(pos_dmactive));
        pin_exp = 2'b01;
        pin_chk = 1'b1;
        check_reg(addr_dmcontrol, dmcontrol_bit(pos_hartreset), dmcontrol_bit(pos_hartreset));
        pin_chk = 1'b0;
        dmi_write_reg(addr_dmcontrol, dmcontrol_bit(pos_dmactive));
        check_reg(addr_dmstatus, 32'h000C_0000, 32'h000C_0000);
        dmi_write_reg(addr_dmcontrol,
                      dmcontrol_bit(pos_ackhavereset) | dmcontrol_bit(pos_dmactive));
        check_reg(addr_dmstatus, 32'h000C_0000, 32'd0);

        @(negedge clk);
        $display("Errors: %0d", errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- bench/hart_model.sv
`timescale 1ns/1ps
`default_nettype none

module hart_model import dm_pkg::*; (
    input  logic      clk,
    input  logic      dm_reset,
    input  logic      halt_req,
    input  logic      resume_req,
    input  logic      exec,
    input  logic      hart_reset,
    input  logic      stall,        // Holds a command open
    input  dmi_data_t command,
    input  dmi_data_t data0_out,
    output logic      halted = 1'b0,
    output logic      done = 1'b0,
    output logic      exception = 1'b0,
    output logic      error = 1'b0,
    output logic      data0_we = 1'b0,
    output dmi_data_t data0_in = '0
);

    logic active = 1'b0;
    int   wait_cycles = 0;

    always @(negedge clk) begin
        done      <= 1'b0;
        exception <= 1'b0;
        error     <= 1'b0;
        data0_we  <= 1'b0;
        if (dm_reset || hart_reset) begin
            halted <= 1'b0;
            active <= 1'b0;
        end else begin
            if (resume_req) begin
                halted <= 1'b0;
            end else if (halt_req) begin
                halted <= 1'b1;
            end
            if (exec && !active) begin
                active      <= 1'b1;
                wait_cycles <= $urandom_range(8, 1);
            end else if (active) begin
                if (wait_cycles > 1) begin
                    wait_cycles <= wait_cycles - 1;
                end else if (!stall) begin
                    active <= 1'b0;
                    if (command[0]) begin
                        exception <= 1'b1; // Bit 0 marks a faulting command
                    end else if (command[1]) begin
                        error <= 1'b1;     // Bit 1 marks a failing command
                    end else begin
                        done     <= 1'b1;
                        data0_we <= 1'b1;
                        data0_in <= data0_out + 1;
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- src/dm_top.sv
`timescale 1ns/1ps
`default_nettype none

module dm_top import dm_pkg::*; (
    input  logic      clk,
    input  logic      dm_reset,
    input  logic      dmi_req,
    input  logic      dmi_write,
    input  dmi_addr_t dmi_addr,
    input  dmi_data_t dmi_wdata,
    output logic      dmi_ack,
    output dmi_data_t dmi_rdata,
    output logic      halt_req,
    output logic      resume_req,
    output logic      exec,
    output dmi_data_t command,
    output dmi_data_t data0_out,
    output dmi_data_t data1_out,
    input  logic      halted,
    input  logic      done,
    input  logic      exception,
    input  logic      error,
    input  dmi_data_t data0_in,
    input  logic      data0_we,
    output logic      ndm_reset_out,
    output logic      hart_reset_out
);

    dm_access_if acc ();
    dm_state_t   state;

    dm_decode u_decode (
        .clk       (clk),
        .dm_reset  (dm_reset),
        .dmi_req   (dmi_req),
        .dmi_write (dmi_write),
        .dmi_addr  (dmi_addr),
        .dmi_wdata (dmi_wdata),
        .dmi_ack   (dmi_ack),
        .dmi_rdata (dmi_rdata),
        .acc       (acc.decode)
    );

    dm_execute u_execute (
        .clk            (clk),
        .dm_reset       (dm_reset),
        .acc            (acc.execute),
        .halted         (halted),
        .done           (done),
        .exception      (exception),
        .error          (error),
        .data0_in       (data0_in),
        .data0_we       (data0_we),
        .halt_req       (halt_req),
        .resume_req     (resume_req),
        .exec           (exec),
        .command        (command),
        .data0_out      (data0_out),
        .data1_out      (data1_out),
        .ndm_reset_out  (ndm_reset_out),
        .hart_reset_out (hart_reset_out),
        .state          (state)
    );

    dm_result u_result (
        .acc        (acc.result),
        .state      (state),
        .hart_reset (hart_reset_out),
        .halted     (halted)
    );

endmodule

`default_nettype wire

//--- src/dm_result.sv
`timescale 1ns/1ps
`default_nettype none

module dm_result import dm_pkg::*; (
    dm_access_if.result acc,
    input  dm_state_t   state,
    input  logic        hart_reset,
    input  logic        halted
);

    logic      available, running, hart_halted;
    dmi_data_t dmstatus, dmcontrol, abstractcs, word;

    assign available   = !hart_reset;
    assign running     = available && !halted;
    assign hart_halted = available && halted;

    // Single hart, so every any/all pair is the same bit
    assign dmstatus = {9'd0, 1'b0, 2'd0,
                       state.havereset, state.havereset,
                       state.resumeack, state.resumeack,
                       2'd0,
                       !available, !available,
                       running, running,
                       hart_halted, hart_halted,
                       1'b1,            // Authenticated
                       1'b0, 1'b1, 1'b0,
                       dm_version};

    assign dmcontrol = {2'd0, state.hartreset, 25'd0, state.haltonreset, 1'b0,
                        state.ndmreset, state.dmactive};

    assign abstractcs = {3'd0, progbufsize_value, 11'd0, state.busy, 1'b0,
                         state.cmderr, 4'd0, datacount_value};

    always_comb begin
        case (acc.addr)
            addr_data0:        word = state.data0;
            addr_data1:        word = state.data1;
            addr_dmcontrol:    word = dmcontrol;
            addr_dmstatus:     word = dmstatus;
            addr_hartinfo:     word = hartinfo_value;
            addr_abstractcs:   word = abstractcs;
            addr_abstractauto: word = state.abstractauto;
            addr_haltsum0:     word = {31'd0, hart_halted};
            default:           word = '0; // command reads zero too
        endcase
    end

    assign acc.rdata = acc.rd ? word : '0;

endmodule

`default_nettype wire

//--- src/dm_execute.sv
`timescale 1ns/1ps
`default_nettype none

module dm_execute import dm_pkg::*; (
    input  logic         clk,
    input  logic         dm_reset,
    dm_access_if.execute acc,
    input  logic         halted,
    input  logic         done,
    input  logic         exception,
    input  logic         error,
    input  dmi_data_t    data0_in,
    input  logic         data0_we,
    output logic         halt_req,
    output logic         resume_req,
    output logic         exec,
    output dmi_data_t    command,
    output dmi_data_t    data0_out,
    output dmi_data_t    data1_out,
    output logic         ndm_reset_out,
    output logic         hart_reset_out,
    output dm_state_t    state
);

    logic      dmactive, ndmreset, hartreset, haltonreset, haltreq;
    logic      busy, havereset, resumeack;
    cmderr_t   cmderr, cmderr_next;
    dmi_data_t abstractauto, data0, data1;
    logic      ctl_wr, cmd_wr, acs_wr, auto_wr, d0_wr, d1_wr;
    logic      ack_wr, busy_err, running;

    assign ctl_wr  = acc.wr && acc.addr == addr_dmcontrol;
    assign cmd_wr  = acc.wr && acc.addr == addr_command;
    assign acs_wr  = acc.wr && acc.addr == addr_abstractcs;
    assign auto_wr = acc.wr && acc.addr == addr_abstractauto;
    assign d0_wr   = acc.wr && acc.addr == addr_data0;
    assign d1_wr   = acc.wr && acc.addr == addr_data1;

    assign resume_req = dmactive && ctl_wr && acc.wdata[pos_resumereq];
    assign ack_wr     = dmactive && ctl_wr && acc.wdata[pos_ackhavereset];

    assign ndm_reset_out  = ndmreset;
    assign hart_reset_out = ndmreset || hartreset;
    assign running        = !hart_reset_out && !halted;

    // Halt out of reset until the host acknowledges it
    assign halt_req  = haltreq || (haltonreset && havereset);
    assign exec      = busy;
    assign data0_out = data0;
    assign data1_out = data1;

    always_ff @(posedge clk) begin
        if (dm_reset) begin
            dmactive <= 1'b0;
        end else if (ctl_wr) begin
            dmactive <= acc.wdata[pos_dmactive];
        end
    end

    // An abstractcs write takes the W1C path below
    assign busy_err = busy && (cmd_wr || auto_wr || d0_wr || d1_wr);

    always_comb begin
        if (acs_wr) begin
            cmderr_next = cmderr_t'(cmderr & ~acc.wdata[10:8]); // W1C
        end else if (cmderr != err_none) begin
            cmderr_next = cmderr;
        end else if (busy_err) begin
            cmderr_next = err_busy;
        end else if (exception) begin
            cmderr_next = err_exception;
        end else if (error) begin
            cmderr_next = err_other;
        end else begin
            cmderr_next = cmderr;
        end
    end

    always_ff @(posedge clk) begin
        if (dm_reset || !dmactive) begin
            ndmreset     <= 1'b0;
            hartreset    <= 1'b0;
            haltonreset  <= 1'b0;
            haltreq      <= 1'b0;
            busy         <= 1'b0;
            cmderr       <= err_none;
            havereset    <= 1'b0;
            resumeack    <= 1'b0;
            command      <= '0;
            abstractauto <= '0;
            data0        <= '0;
            data1        <= '0;
        end else begin
            if (ctl_wr) begin
                haltreq   <= acc.wdata[pos_haltreq];
                hartreset <= acc.wdata[pos_hartreset];
                ndmreset  <= acc.wdata[pos_ndmreset];
                if (acc.wdata[pos_clrresethaltreq]) begin
                    haltonreset <= 1'b0;
                end else if (acc.wdata[pos_setresethaltreq]) begin
                    haltonreset <= 1'b1;
                end
            end
            if (cmd_wr && !busy && cmderr == err_none) begin
                command <= acc.wdata;
                busy    <= 1'b1;
            end else if (busy && (done || exception || error)) begin
                busy <= 1'b0;
            end
            if (auto_wr && !busy) abstractauto <= acc.wdata & abstractauto_mask;
            if (d0_wr && !busy) data0 <= acc.wdata;
            if (data0_we) data0 <= data0_in; // Hart result
            if (d1_wr && !busy) data1 <= acc.wdata;
            cmderr    <= cmderr_next;
            havereset <= (havereset || hart_reset_out) && !ack_wr;
            resumeack <= (resumeack || running) && !resume_req;
        end
    end

    assign state.dmactive     = dmactive;
    assign state.ndmreset     = ndmreset;
    assign state.hartreset    = hartreset;
    assign state.haltonreset  = haltonreset;
    assign state.busy         = busy;
    assign state.cmderr       = cmderr;
    assign state.havereset    = havereset;
    assign state.resumeack    = resumeack;
    assign state.abstractauto = abstractauto;
    assign state.data0        = data0;
    assign state.data1        = data1;

endmodule

`default_nettype wire

//--- src/dm_decode.sv
`timescale 1ns/1ps
`default_nettype none

module dm_decode import dm_pkg::*; (
    input  logic        clk,
    input  logic        dm_reset,
    input  logic        dmi_req,
    input  logic        dmi_write,
    input  dmi_addr_t   dmi_addr,
    input  dmi_data_t   dmi_wdata,
    output logic        dmi_ack,
    output dmi_data_t   dmi_rdata,
    dm_access_if.decode acc
);

    typedef enum logic [1:0] {
        st_idle,
        st_strobe,
        st_ack
    } dec_state_t;

    dec_state_t st;
    logic       write_q;

    always_ff @(posedge clk) begin
        if (dm_reset) begin
            st      <= st_idle;
            write_q <= 1'b0;
            acc.wr  <= 1'b0;
            acc.rd  <= 1'b0;
            dmi_ack <= 1'b0;
        end else begin
            acc.wr <= 1'b0;
            acc.rd <= 1'b0;
            case (st)
                st_idle: begin
                    if (dmi_req) begin
                        write_q <= dmi_write;
                        st      <= st_strobe;
                    end
                end
                st_strobe: begin
                    acc.wr <= write_q;
                    acc.rd <= !write_q;
                    st     <= st_ack;
                end
                st_ack: begin
                    if (!dmi_ack) begin
                        dmi_ack <= 1'b1;
                    end else if (!dmi_req) begin // Host finished phase 3
                        dmi_ack <= 1'b0;
                        st      <= st_idle;
                    end
                end
                default: begin
                    st <= st_idle;
                end
            endcase
        end
    end

    // Request fields and read word
    always_ff @(posedge clk) begin
        if (st == st_idle && dmi_req) begin
            acc.addr  <= dmi_addr;
            acc.wdata <= dmi_wdata;
        end
        if (st == st_ack && !dmi_ack) begin
            dmi_rdata <= acc.rdata; // rd strobe is high in this cycle
        end
    end

endmodule

`default_nettype wire

//--- src/dm_access_if.sv
`timescale 1ns/1ps
`default_nettype none

// One decoded DMI access and its read data
interface dm_access_if import dm_pkg::*; ();

    dmi_addr_t addr;
    dmi_data_t wdata;
    logic      wr;    // One cycle
    logic      rd;    // One cycle
    dmi_data_t rdata;

    modport decode (
        output addr,
        output wdata,
        output wr,
        output rd,
        input  rdata
    );

    modport execute (
        input addr,
        input wdata,
        input wr
    );

    modport result (
        input  addr,
        input  rd,
        output rdata
    );

endinterface

`default_nettype wire

//--- src/dm_pkg.sv
`default_nettype none

package dm_pkg;

    typedef logic [6:0]  dmi_addr_t;
    typedef logic [31:0] dmi_data_t;

    // DMI register map
    localparam dmi_addr_t addr_data0        = 7'h04;
    localparam dmi_addr_t addr_data1        = 7'h05;
    localparam dmi_addr_t addr_dmcontrol    = 7'h10;
    localparam dmi_addr_t addr_dmstatus     = 7'h11;
    localparam dmi_addr_t addr_hartinfo     = 7'h12;
    localparam dmi_addr_t addr_abstractcs   = 7'h16;
    localparam dmi_addr_t addr_command      = 7'h17;
    localparam dmi_addr_t addr_abstractauto = 7'h18;
    localparam dmi_addr_t addr_haltsum0     = 7'h40;

    // dmcontrol bits
    localparam int pos_haltreq         = 31;
    localparam int pos_resumereq       = 30;
    localparam int pos_hartreset       = 29;
    localparam int pos_ackhavereset    = 28;
    localparam int pos_setresethaltreq = 3;
    localparam int pos_clrresethaltreq = 2;
    localparam int pos_ndmreset        = 1;
    localparam int pos_dmactive        = 0;

    typedef enum logic [2:0] {
        err_none      = 3'd0,
        err_busy      = 3'd1,
        err_exception = 3'd3,
        err_other     = 3'd5
    } cmderr_t;

    localparam dmi_data_t  hartinfo_value    = 32'h0000_2000; // datasize 2, CSR shadowed
    localparam dmi_data_t  abstractauto_mask = 32'hFFFF_0FFF;
    localparam logic [3:0] datacount_value   = 4'd2;
    localparam logic [4:0] progbufsize_value = 5'd0;
    localparam logic [3:0] dm_version        = 4'd2;

    // Execute state seen by the read path
    typedef struct packed {
        logic      dmactive;
        logic      ndmreset;
        logic      hartreset;
        logic      haltonreset;
        logic      busy;
        cmderr_t   cmderr;
        logic      havereset;
        logic      resumeack;
        dmi_data_t abstractauto;
        dmi_data_t data0;
        dmi_data_t data1;
    } dm_state_t;

endpackage

`default_nettype wire
